/* sources.f */
source/mem_pkg.sv
source/video_pkg.sv
source/mem_arbiter.sv
source/stream_fifo.sv
source/rtg_video.sv
source/aux_audio.sv
source/rtg_audio_top.sv
verif/tb_rtg_audio.sv

/* run_sim.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_rtg_audio -f sources.f -o tb_rtg_audio \
  && ./obj_dir/tb_rtg_audio > sim.log 2>&1 \
  || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

/* verif/tb_rtg_audio.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rtg_audio;

  localparam int TICK    = 64;                          // Audio frame period under test
  localparam int PW      = 5;                           // Six clocks per pixel
  localparam int VBE     = 2;                           // Lines held after vblank
  localparam int HS_LEN  = 4;
  localparam int HB_LEN  = 16;
  localparam int ACT_LEN = 60;                          // Ten pixels per line
  localparam int LINES   = 5;
  localparam mem_pkg::mem_addr_t BASE = 23'h01_2340;

  logic                          clk_114 = 1'b0;
  logic                          arst_n;
  logic                          mem_req;
  mem_pkg::mem_addr_t            mem_addr;
  mem_pkg::mem_word_t            mem_rdata = '0;
  logic                          mem_fill = 1'b0;
  logic                          rtg_ena;
  mem_pkg::mem_addr_t            base_addr;
  logic [video_pkg::PIX_WIDTH_W-1:0] pixel_width;
  logic [video_pkg::VB_END_W-1:0]    vb_end;
  logic                          hblank;
  logic                          vblank;
  logic                          hsync;
  video_pkg::color_t             native_red;
  video_pkg::color_t             native_green;
  video_pkg::color_t             native_blue;
  video_pkg::color_t             red;
  video_pkg::color_t             green;
  video_pkg::color_t             blue;
  logic                          pixel_strobe;
  logic                          aud_ena;
  logic [15:0]                   native_left;
  logic [15:0]                   native_right;
  logic [15:0]                   audio_left;
  logic [15:0]                   audio_right;

  int                 checks = 0;
  int                 errors = 0;
  int                 timeouts = 0;
  int                 cyc = 0;                          // Video cycle index
  int                 last_strobe = -1;
  int                 pix_n = 0;                        // Pixels since frame start
  int                 strobes = 0;
  bit                 colour_due = 1'b0;
  mem_pkg::mem_word_t due_word;
  int                 aud_k = 0;                        // Next audio sample index
  int                 clamp_hi = 0;
  int                 clamp_lo = 0;

  rtg_audio_top #(.TICK_DIV(TICK)) rtg_audio_top_inst (
    .clk_114      (clk_114),
    .arst_n       (arst_n),
    .mem_req      (mem_req),
    .mem_addr     (mem_addr),
    .mem_rdata    (mem_rdata),
    .mem_fill     (mem_fill),
    .rtg_ena      (rtg_ena),
    .base_addr    (base_addr),
    .pixel_width  (pixel_width),
    .vb_end       (vb_end),
    .hblank       (hblank),
    .vblank       (vblank),
    .hsync        (hsync),
    .native_red   (native_red),
    .native_green (native_green),
    .native_blue  (native_blue),
    .red          (red),
    .green        (green),
    .blue         (blue),
    .pixel_strobe (pixel_strobe),
    .aud_ena      (aud_ena),
    .native_left  (native_left),
    .native_right (native_right),
    .audio_left   (audio_left),
    .audio_right  (audio_right)
  );

  always #20 clk_114 = ~clk_114;                        // 40 ns period

  ////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic mem_pkg::mem_word_t mem_word(input mem_pkg::mem_addr_t a);
    return (a[15:0] ^ 16'h5A3C) ^ {a[22:16], 9'h000};   // Fill pattern over all address bits
  endfunction

  function automatic video_pkg::color_t grow5(input logic [4:0] f);
    return (8'(f) << 3) | (8'(f) >> 2);
  endfunction

  // Swap, signed add with clamp, offset binary
  function automatic logic [15:0] mix_model(input logic [15:0] w, input logic [15:0] n);
    int s;
    s = int'($signed({w[7:0], w[15:8]})) + int'($signed(n));
    if (s > 32767) s = 32767;
    if (s < -32768) s = -32768;
    return 16'(s) ^ 16'h8000;
  endfunction

  ////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////

  logic               mem_busy = 1'b0;
  mem_pkg::mem_addr_t burst_addr;
  int                 burst_idx;
  int unsigned        gap;
  logic [31:0]        rng = 32'd71;

  always @(negedge clk_114) begin
    mem_fill = 1'b0;
    if (!arst_n) begin
      mem_busy = 1'b0;
    end else if (!mem_busy) begin
      if (mem_req) begin                                // Latch burst start
        mem_busy   = 1'b1;
        burst_addr = mem_addr;
        burst_idx  = 0;
        rng        = xorshift(rng);
        gap        = rng % 5;                           // 1 to 5 cycles latency
      end
    end else if (gap != 0) begin
      gap = gap - 1;
    end else begin
      mem_fill  = 1'b1;
      mem_rdata = mem_word(burst_addr + mem_pkg::mem_addr_t'(burst_idx));
      burst_idx = burst_idx + 1;
      if (burst_idx == mem_pkg::BURST_LEN) begin
        mem_busy = 1'b0;
      end else begin
        rng = xorshift(rng);
        gap = rng % 3;                                  // Gap between fills
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic sample();
    @(negedge clk_114);
    #5;                                                 // Mid low phase, all settled
  endtask

  // One video clock, drive then check strobe and colour
  task automatic video_cycle(input logic hb, input logic vb, input logic hs, input bit live);
    @(negedge clk_114);
    hblank = hb;
    vblank = vb;
    hsync  = hs;
    #5;
    if (colour_due) begin
      compare("red", 32'(red), 32'(grow5(due_word[14:10])));
      compare("green", 32'(green), 32'(grow5(due_word[9:5])));
      compare("blue", 32'(blue), 32'(grow5(due_word[4:0])));
      colour_due = 1'b0;
    end
    if (pixel_strobe && !(live && !hb)) begin
      compare("strobe while blanked", 32'(pixel_strobe), 32'(0));
    end else if (pixel_strobe) begin
      if (last_strobe >= 0) begin
        compare("strobe spacing", cyc - last_strobe, PW + 1);
      end
      last_strobe = cyc;
      due_word    = mem_word(base_addr + mem_pkg::mem_addr_t'(pix_n));
      pix_n++;
      strobes++;
      colour_due  = 1'b1;
    end
    cyc++;
  endtask

  task automatic video_line(input bit live);
    last_strobe = -1;                                   // Spacing only within a line
    for (int i = 0; i < HB_LEN + ACT_LEN; i++) begin
      video_cycle(i < HB_LEN, 1'b0, i < HS_LEN, live);
    end
  endtask

  // Waits for the left output of one stereo frame, then the right
  task automatic audio_frame();
    logic [15:0] prev;
    logic [15:0] exp_l;
    logic [15:0] exp_r;
    int          t;
    prev  = audio_left;
    exp_l = mix_model(mem_word(mem_pkg::AUD_BASE + mem_pkg::mem_addr_t'(aud_k)), native_left);
    exp_r = mix_model(mem_word(mem_pkg::AUD_BASE + mem_pkg::mem_addr_t'(aud_k + 1)),
                      native_right);
    t = 0;
    while (audio_left === prev && t < 3 * TICK) begin
      sample();
      t++;
    end
    if (audio_left === prev) begin
      $display("Timeout: audio_left did not update within %0d cycles", 3 * TICK);
      timeouts++;
      return;
    end
    compare("audio_left", 32'(audio_left), 32'(exp_l));
    sample();                                           // Right follows one cycle later
    compare("audio_right", 32'(audio_right), 32'(exp_r));
    if (exp_l == 16'hFFFF) clamp_hi++;
    if (exp_r == 16'h0000) clamp_lo++;
    aud_k += 2;
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  // Sampled while arst_n is low, natives nonzero and timing unblanked
  task automatic reset_test();
    for (int i = 0; i < 3; i++) begin
      @(negedge clk_114);
      rtg_ena = (i == 2);                               // Last cycle with RTG timing live
      #5;
      compare("mem_req after reset", 32'(mem_req), 32'(0));
      compare("pixel_strobe after reset", 32'(pixel_strobe), 32'(0));
      compare("colour after reset", 32'({red, green, blue}), 32'(0));
      compare("audio_left after reset", 32'(audio_left), 32'h8000);
      compare("audio_right after reset", 32'(audio_right), 32'h8000);
    end
    @(negedge clk_114);
    arst_n  = 1'b1;
    rtg_ena = 1'b0;
    hblank  = 1'b1;
    vblank  = 1'b1;
  endtask

  task automatic native_test();
    video_pkg::color_t pr;
    video_pkg::color_t pg;
    video_pkg::color_t pb;
    for (int i = 0; i < 30; i++) begin
      @(negedge clk_114);
      native_red   = 8'(i * 29 + 3);
      native_green = 8'(i * 53);
      native_blue  = ~native_red;
      #5;
      if (i > 0) begin                                  // Previous cycle's inputs
        compare("native red", 32'(red), 32'(pr));
        compare("native green", 32'(green), 32'(pg));
        compare("native blue", 32'(blue), 32'(pb));
      end
      compare("mem_req with paths off", 32'(mem_req), 32'(0));
      compare("pixel_strobe with rtg off", 32'(pixel_strobe), 32'(0));
      pr = native_red;
      pg = native_green;
      pb = native_blue;
    end
  endtask

  task automatic hicolour_test();
    @(negedge clk_114);
    vblank = 1'b1;
    hblank = 1'b1;
    @(negedge clk_114);
    rtg_ena     = 1'b1;
    base_addr   = BASE;
    pixel_width = video_pkg::PIX_WIDTH_W'(PW);
    vb_end      = video_pkg::VB_END_W'(VBE);
    for (int fr = 0; fr < 2; fr++) begin                // Second frame checks the rewind
      pix_n   = 0;
      strobes = 0;
      for (int i = 0; i < 24; i++) begin
        video_cycle(1'b1, 1'b1, 1'b0, 1'b0);
      end
      for (int ln = 1; ln <= LINES; ln++) begin
        video_line(ln >= VBE);
      end
      video_cycle(1'b1, 1'b1, 1'b0, 1'b0);              // Colour of the last pixel
      compare("strobes per frame", strobes, (LINES - VBE + 1) * (ACT_LEN / (PW + 1)));
    end
  endtask

  task automatic audio_test();
    @(negedge clk_114);
    rtg_ena      = 1'b0;
    native_left  = 16'h0000;
    native_right = 16'h0000;
    aud_ena      = 1'b1;
    for (int f = 0; f < 6; f++) begin
      audio_frame();
      if (timeouts != 0) return;
    end
  endtask

  task automatic saturation_test();
    for (int f = 0; f < 100; f++) begin                 // Runs into negative samples
      @(negedge clk_114);
      native_left  = f[0] ? 16'h0000 : 16'h7FFF;        // Alternate so left keeps moving
      native_right = f[0] ? 16'h0000 : 16'h8000;
      audio_frame();
      if (timeouts != 0) return;
    end
    compare("positive clamp seen", 32'(clamp_hi > 0), 32'(1));
    compare("negative clamp seen", 32'(clamp_lo > 0), 32'(1));
  endtask

  ////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////

  initial begin
    arst_n       = 1'b0;
    rtg_ena      = 1'b0;
    base_addr    = '0;
    pixel_width  = '0;
    vb_end       = '0;
    hblank       = 1'b0;                                // Unblanked, only reset holds strobe
    vblank       = 1'b0;
    hsync        = 1'b0;
    native_red   = 8'hA5;
    native_green = 8'h5A;
    native_blue  = 8'hC3;
    aud_ena      = 1'b0;
    native_left  = '0;
    native_right = '0;
    reset_test();
    native_test();
    hicolour_test();
    audio_test();
    if (timeouts == 0) begin
      saturation_test();
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/rtg_audio_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rtg_audio_top #(
  parameter int FIFO_DEPTH = 16,                        // Words per fetcher
  parameter int TICK_DIV   = 2572                       // Audio frame period
) (
  input  wire                                clk_114,
  input  wire                                arst_n,
  // Memory port
  output wire                                mem_req,
  output wire mem_pkg::mem_addr_t            mem_addr,
  input  wire mem_pkg::mem_word_t            mem_rdata,
  input  wire                                mem_fill,
  // Video
  input  wire                                rtg_ena,
  input  wire mem_pkg::mem_addr_t            base_addr,     // Frame start
  input  wire [video_pkg::PIX_WIDTH_W-1:0]   pixel_width,
  input  wire [video_pkg::VB_END_W-1:0]      vb_end,
  input  wire                                hblank,
  input  wire                                vblank,
  input  wire                                hsync,
  input  wire video_pkg::color_t             native_red,
  input  wire video_pkg::color_t             native_green,
  input  wire video_pkg::color_t             native_blue,
  output wire video_pkg::color_t             red,
  output wire video_pkg::color_t             green,
  output wire video_pkg::color_t             blue,
  output wire                                pixel_strobe,
  // Audio
  input  wire                                aud_ena,
  input  wire [mem_pkg::MEM_DATA_W-1:0]      native_left,
  input  wire [mem_pkg::MEM_DATA_W-1:0]      native_right,
  output wire [mem_pkg::MEM_DATA_W-1:0]      audio_left,
  output wire [mem_pkg::MEM_DATA_W-1:0]      audio_right
);

  wire                     vid_req;
  wire mem_pkg::mem_addr_t vid_addr;
  wire                     vid_fill;
  wire mem_pkg::mem_word_t vid_q;
  wire                     vid_restart;
  wire                     aud_req;
  wire mem_pkg::mem_addr_t aud_addr;
  wire                     aud_fill;
  wire mem_pkg::mem_word_t aud_q;
  wire                     aud_restart;
  wire                     aud_rd;

  ////////////////////////////////////////////////////////////
  // Shared memory port
  ////////////////////////////////////////////////////////////

  mem_arbiter mem_arbiter_inst (
    .clk_114  (clk_114),
    .arst_n   (arst_n),
    .vid_req  (vid_req),
    .vid_addr (vid_addr),
    .vid_fill (vid_fill),
    .aud_req  (aud_req),
    .aud_addr (aud_addr),
    .aud_fill (aud_fill),
    .mem_req  (mem_req),
    .mem_addr (mem_addr),
    .mem_fill (mem_fill)
  );

  ////////////////////////////////////////////////////////////
  // RTG video path
  ////////////////////////////////////////////////////////////

  stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) vid_fifo_inst (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .restart    (vid_restart),
    .base       (base_addr),
    .fetch_req  (vid_req),
    .fetch_addr (vid_addr),
    .fetch_fill (vid_fill),
    .fetch_data (mem_rdata),                            // Data bus shared by both
    .rd_req     (pixel_strobe),
    .q          (vid_q)
  );

  rtg_video rtg_video_inst (
    .clk_114      (clk_114),
    .arst_n       (arst_n),
    .rtg_ena      (rtg_ena),
    .pixel_width  (pixel_width),
    .vb_end       (vb_end),
    .hblank       (hblank),
    .vblank       (vblank),
    .hsync        (hsync),
    .native_red   (native_red),
    .native_green (native_green),
    .native_blue  (native_blue),
    .q            (vid_q),
    .restart      (vid_restart),
    .rd_req       (pixel_strobe),
    .red          (red),
    .green        (green),
    .blue         (blue)
  );

  ////////////////////////////////////////////////////////////
  // Aux audio path
  ////////////////////////////////////////////////////////////

  stream_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) aud_fifo_inst (
    .clk_114    (clk_114),
    .arst_n     (arst_n),
    .restart    (aud_restart),
    .base       (mem_pkg::AUD_BASE),
    .fetch_req  (aud_req),
    .fetch_addr (aud_addr),
    .fetch_fill (aud_fill),
    .fetch_data (mem_rdata),
    .rd_req     (aud_rd),
    .q          (aud_q)
  );

  aux_audio #(.TICK_DIV(TICK_DIV)) aux_audio_inst (
    .clk_114      (clk_114),
    .arst_n       (arst_n),
    .aud_ena      (aud_ena),
    .native_left  (native_left),
    .native_right (native_right),
    .q            (aud_q),
    .restart      (aud_restart),
    .rd_req       (aud_rd),
    .audio_left   (audio_left),
    .audio_right  (audio_right)
  );

endmodule

`default_nettype wire

/* source/aux_audio.sv */
`timescale 1ns/1ps
`default_nettype none

module aux_audio #(
  parameter int TICK_DIV = 2572                         // Clocks per stereo frame
) (
  input  wire                                clk_114,
  input  wire                                arst_n,
  input  wire                                aud_ena,
  input  wire [mem_pkg::MEM_DATA_W-1:0]      native_left,   // Signed chipset audio
  input  wire [mem_pkg::MEM_DATA_W-1:0]      native_right,
  input  wire mem_pkg::mem_word_t            q,             // FIFO head sample
  output logic                               restart,
  output logic                               rd_req,
  output logic [mem_pkg::MEM_DATA_W-1:0]     audio_left,    // Offset binary
  output logic [mem_pkg::MEM_DATA_W-1:0]     audio_right
);

  localparam int DW = mem_pkg::MEM_DATA_W;
  localparam int TW = $clog2(TICK_DIV);

  logic [TW-1:0]      tick_cnt;
  logic               tick;                             // Left pop
  logic               tick_d;                           // Right pop, left out
  logic               tick_dd;                          // Right out
  mem_pkg::mem_word_t left_smp;
  mem_pkg::mem_word_t right_smp;

  // Samples are stored little endian
  function automatic mem_pkg::mem_word_t swap(input mem_pkg::mem_word_t w);
    return {w[DW/2-1:0], w[DW-1:DW/2]};
  endfunction

  // Signed saturating add, then sign bit flipped
  function automatic logic [DW-1:0] mix(input logic [DW-1:0] a, input logic [DW-1:0] b);
    logic [DW:0]   sum;
    logic [DW-1:0] sat;
    sum = {a[DW-1], a} + {b[DW-1], b};
    if (sum[DW] != sum[DW-1]) begin                     // Overflow
      sat = sum[DW] ? {1'b1, {(DW-1){1'b0}}} : {1'b0, {(DW-1){1'b1}}};
    end else begin
      sat = sum[DW-1:0];
    end
    return {~sat[DW-1], sat[DW-2:0]};
  endfunction

  assign restart = !aud_ena;
  assign rd_req  = tick || tick_d;                      // Two pops back to back

  ////////////////////////////////////////////////////////////
  // Sample rate divider
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
      tick     <= 1'b0;
      tick_d   <= 1'b0;
      tick_dd  <= 1'b0;
    end else begin
      tick_d  <= tick;
      tick_dd <= tick_d;
      if (!aud_ena) begin                               // Phase restarts on enable
        tick_cnt <= '0;
        tick     <= 1'b0;
      end else if (tick_cnt == TW'(TICK_DIV - 1)) begin
        tick_cnt <= '0;
        tick     <= 1'b1;
      end else begin
        tick_cnt <= tick_cnt + 1'b1;
        tick     <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Capture and mix
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (tick) begin
      left_smp <= swap(q);                              // First word is left
    end
    if (tick_d) begin
      right_smp <= swap(q);
    end
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      audio_left  <= {1'b1, {(DW-1){1'b0}}};            // Midscale
      audio_right <= {1'b1, {(DW-1){1'b0}}};
    end else begin
      if (tick_d) begin
        audio_left <= mix(left_smp, native_left);
      end
      if (tick_dd) begin
        audio_right <= mix(right_smp, native_right);
      end
    end
  end

endmodule

`default_nettype wire

/* source/rtg_video.sv */
`timescale 1ns/1ps
`default_nettype none

module rtg_video (
  input  wire                                 clk_114,
  input  wire                                 arst_n,
  input  wire                                 rtg_ena,      // RTG screen on
  input  wire [video_pkg::PIX_WIDTH_W-1:0]    pixel_width,  // Clocks per pixel - 1
  input  wire [video_pkg::VB_END_W-1:0]       vb_end,       // Extra blank lines
  input  wire                                 hblank,
  input  wire                                 vblank,       // From chipset
  input  wire                                 hsync,
  input  wire video_pkg::color_t              native_red,
  input  wire video_pkg::color_t              native_green,
  input  wire video_pkg::color_t              native_blue,
  input  wire mem_pkg::mem_word_t             q,            // FIFO head, 5:5:5
  output logic                                restart,
  output logic                                rd_req,       // Pixel strobe
  output video_pkg::color_t                   red,
  output video_pkg::color_t                   green,
  output video_pkg::color_t                   blue
);

  localparam int FW = video_pkg::FIELD_W;

  video_pkg::vblank_state_e            vb_state;
  logic [video_pkg::VB_END_W-1:0]      vb_cnt;          // Lines since vblank fell
  logic [video_pkg::PIX_WIDTH_W-1:0]   pix_cnt;
  logic                                hsync_d;
  logic                                blank;

  // 5-bit field to 8 bits, top bits repeated into the LSBs
  function automatic video_pkg::color_t expand(input logic [FW-1:0] f);
    return {f, f[FW-1 -: video_pkg::COLOR_W - FW]};
  endfunction

  assign restart = vblank || !rtg_ena;                  // Rewind fetcher every frame
  assign blank   = (vb_state == video_pkg::VB_HOLD) || hblank;
  assign rd_req  = rtg_ena && !blank && (pix_cnt == pixel_width);

  ////////////////////////////////////////////////////////////
  // Vertical blank extension
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      vb_state <= video_pkg::VB_HOLD;
      vb_cnt   <= '0;
      hsync_d  <= 1'b0;
    end else begin
      hsync_d <= hsync;
      if (vblank) begin
        vb_state <= video_pkg::VB_HOLD;
        vb_cnt   <= '0;
      end else if (vb_cnt == vb_end) begin
        vb_state <= video_pkg::VB_ACTIVE;               // Count stays put until vblank
      end else if (hsync && !hsync_d) begin
        vb_cnt <= vb_cnt + 1'b1;                        // One per line
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Pixel clock divider
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      pix_cnt <= '0;
    end else if (blank || rd_req) begin
      pix_cnt <= '0;                                    // Realign at line start
    end else begin
      pix_cnt <= pix_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Colour output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      red   <= '0;
      green <= '0;
      blue  <= '0;
    end else if (!rtg_ena) begin                        // Native chipset video
      red   <= native_red;
      green <= native_green;
      blue  <= native_blue;
    end else if (rd_req) begin                          // Head word, popped this edge
      red   <= expand(q[2*FW +: FW]);
      green <= expand(q[FW +: FW]);
      blue  <= expand(q[0 +: FW]);
    end
  end

endmodule

`default_nettype wire

/* source/stream_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter int FIFO_DEPTH = 16                         // Words, power of two
) (
  input  wire                clk_114,
  input  wire                arst_n,
  input  wire                restart,                   // Flush and rewind to base
  input  wire mem_pkg::mem_addr_t base,
  output logic               fetch_req,                 // Held for a whole burst
  output mem_pkg::mem_addr_t fetch_addr,                // Burst start address
  input  wire                fetch_fill,
  input  wire mem_pkg::mem_word_t fetch_data,
  input  wire                rd_req,                    // Pop at this clock edge
  output mem_pkg::mem_word_t q                          // Head word
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int BW    = $clog2(mem_pkg::BURST_LEN);

  mem_pkg::mem_word_t buf_mem [FIFO_DEPTH];             // Circular word store
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [CNT_W-1:0]   cnt;                              // Words held
  logic [BW-1:0]      burst_cnt;                        // Fills in current burst
  logic               discard;                          // Burst outlived a restart
  logic               wr_en;
  logic               rd_en;
  logic               burst_end;
  logic               room;

  assign wr_en     = fetch_fill && fetch_req && !discard && !restart;
  assign rd_en     = rd_req && (cnt != '0) && !restart; // Empty pop keeps stale head
  assign burst_end = fetch_fill && fetch_req && (burst_cnt == BW'(mem_pkg::BURST_LEN - 1));
  assign room      = cnt <= CNT_W'(FIFO_DEPTH - mem_pkg::BURST_LEN);
  assign q         = buf_mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // Burst prefetch
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      fetch_req  <= 1'b0;
      fetch_addr <= '0;
      burst_cnt  <= '0;
      discard    <= 1'b0;
    end else begin
      if (burst_end) begin                              // Drop req for at least a cycle
        fetch_req <= 1'b0;
        burst_cnt <= '0;
        discard   <= 1'b0;
        if (discard || restart) begin
          fetch_addr <= base;
        end else begin
          fetch_addr <= fetch_addr + mem_pkg::mem_addr_t'(mem_pkg::BURST_LEN);
        end
      end else if (fetch_req) begin                     // Address frozen mid-burst
        if (fetch_fill) begin
          burst_cnt <= burst_cnt + 1'b1;
        end
        if (restart) begin
          discard <= 1'b1;                              // Let it finish, drop words
        end
      end else if (restart) begin
        fetch_addr <= base;
      end else if (room) begin
        fetch_req <= 1'b1;                              // Space for a full burst
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Word store and occupancy
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114) begin
    if (wr_en) begin
      buf_mem[wr_ptr] <= fetch_data;
    end
  end

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else if (restart) begin                         // Flush
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;                        // Wraps at depth
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      cnt <= cnt + CNT_W'(wr_en) - CNT_W'(rd_en);
    end
  end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  wire                clk_114,
  input  wire                arst_n,
  input  wire                vid_req,                   // Video fetcher wants a burst
  input  wire mem_pkg::mem_addr_t vid_addr,
  output logic               vid_fill,
  input  wire                aud_req,                   // Audio fetcher wants a burst
  input  wire mem_pkg::mem_addr_t aud_addr,
  output logic               aud_fill,
  output logic               mem_req,                   // Level, held until first fill
  output mem_pkg::mem_addr_t mem_addr,
  input  wire                mem_fill                   // One pulse per returned word
);

  localparam int BW = $clog2(mem_pkg::BURST_LEN);

  mem_pkg::arb_state_e state;
  logic [BW-1:0]       fill_cnt;                        // Words seen in this burst
  logic                last_fill;

  assign last_fill = mem_fill && (fill_cnt == BW'(mem_pkg::BURST_LEN - 1));

  // Request only until the first word lands
  assign mem_req  = (state != mem_pkg::ARB_IDLE) && (fill_cnt == '0);
  assign mem_addr = (state == mem_pkg::ARB_AUDIO) ? aud_addr : vid_addr;
  assign vid_fill = mem_fill && (state == mem_pkg::ARB_VIDEO);   // Route to owner
  assign aud_fill = mem_fill && (state == mem_pkg::ARB_AUDIO);

  ////////////////////////////////////////////////////////////
  // Burst-level grant FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_114 or negedge arst_n) begin
    if (!arst_n) begin
      state    <= mem_pkg::ARB_IDLE;
      fill_cnt <= '0;
    end else begin
      case (state)
        mem_pkg::ARB_IDLE: begin
          if (vid_req) begin                            // Video always wins
            state <= mem_pkg::ARB_VIDEO;
          end else if (aud_req) begin
            state <= mem_pkg::ARB_AUDIO;
          end
        end
        default: begin
          if (last_fill) begin                          // Burst done, pick again
            state    <= mem_pkg::ARB_IDLE;
            fill_cnt <= '0;
          end else if (mem_fill) begin
            fill_cnt <= fill_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/video_pkg.sv */
`default_nettype none

package video_pkg;

  ////////////////////////////////////////////////////////////
  // Pixel formats
  ////////////////////////////////////////////////////////////

  localparam int COLOR_W = 8;                           // Output channel width
  localparam int FIELD_W = 5;                           // Hi-colour 5:5:5 field

  typedef logic [COLOR_W-1:0] color_t;

  ////////////////////////////////////////////////////////////
  // Timing fields
  ////////////////////////////////////////////////////////////

  localparam int PIX_WIDTH_W = 4;                       // Clocks per pixel minus one
  localparam int VB_END_W    = 7;                       // Lines held after vblank

  typedef enum logic {
    VB_HOLD,                                            // Still inside RTG blank area
    VB_ACTIVE                                           // Visible lines
  } vblank_state_e;

endpackage

`default_nettype wire

/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  ////////////////////////////////////////////////////////////
  // Shared memory port
  ////////////////////////////////////////////////////////////

  localparam int MEM_ADDR_W = 23;                       // Word address, 8M words
  localparam int MEM_DATA_W = 16;                       // One chip word
  localparam int BURST_LEN  = 4;                        // Words per granted burst

  typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [MEM_DATA_W-1:0] mem_word_t;

  ////////////////////////////////////////////////////////////
  // Arbiter and memory map
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ARB_IDLE,                                           // No burst outstanding
    ARB_VIDEO,                                          // RTG fetcher owns the port
    ARB_AUDIO                                           // Aux audio fetcher owns it
  } arb_state_e;

  // Aux audio ring sits at 0x300000 words in SDRAM
  localparam mem_addr_t AUD_BASE = 23'h30_0000;

endpackage

`default_nettype wire
